/* src/psoc_audio_pkg.sv */
// Audio peripheral shared definitions
// Sample pair type, register map and control bit positions

package psoc_audio_pkg;

    // One channel sample, two's complement
    localparam int SAMPLE_BITS = 24;

    // Stereo pair as stored in the FIFO, left in the upper half
    typedef struct packed {
        logic [SAMPLE_BITS-1:0] left;
        logic [SAMPLE_BITS-1:0] right;
    } sample_pair_t;

    // Register word offsets, low 5 address bits decoded
    localparam logic [4:0] REG_CTRL   = 5'h00;
    localparam logic [4:0] REG_STATUS = 5'h04;
    localparam logic [4:0] REG_THRESH = 5'h08;
    localparam logic [4:0] REG_LEFT   = 5'h0c;
    localparam logic [4:0] REG_RIGHT  = 5'h10;

    // CTRL bit positions
    localparam int CTRL_I2S_EN   = 0;
    localparam int CTRL_DAC_EN   = 1;
    localparam int CTRL_DAC_MODE = 2;
    localparam int CTRL_SW_RST   = 3;

    // FIFO low threshold after reset
    localparam int THRESH_RESET = 16;

endpackage

/* src/audio_ctrl_if.sv */
// Audio control bundle
// Control levels and the soft reset pulse from the register file

`timescale 1ns/1ps

interface audio_ctrl_if #(
    parameter int FIFO_LEN_BITS = 8
);

    logic                   i2s_enable;
    logic                   dac_enable;
    logic                   dac_mode;
    // One cycle pulse
    logic                   sw_rst;
    logic [FIFO_LEN_BITS:0] threshold;

    // Register file side
    modport ctrl (
        output i2s_enable, dac_enable, dac_mode, sw_rst, threshold
    );

    // Datapath side
    modport datapath (
        input i2s_enable, dac_enable, dac_mode, sw_rst, threshold
    );

endinterface

/* src/clock_generator.sv */
// Clock enable generator
// Free-running divider giving strobes at 1/4 and 1/16 of clk

`timescale 1ns/1ps

module clock_generator (
    input  logic clk,
    input  logic rst_i,
    output logic clk_en_4_o,
    output logic clk_en_16_o
);

    logic [3:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 4'd1;
        end
    end

    // Strobes fire on the last count of each period
    assign clk_en_4_o  = (cnt_q[1:0] == 2'b11);
    assign clk_en_16_o = (cnt_q == 4'hf);

endmodule

/* src/sample_fifo.sv */
// Sample pair FIFO
// Synchronous first-word fall-through buffer with a fill level

`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_LEN_BITS = 8
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         wr_i,
    input  psoc_audio_pkg::sample_pair_t wr_data_i,
    input  logic                         rd_i,
    output psoc_audio_pkg::sample_pair_t rd_data_o,
    output logic                         empty_o,
    output logic                         full_o,
    output logic [FIFO_LEN_BITS:0]       level_o
);

    import psoc_audio_pkg::*;

    localparam int DEPTH = 1 << FIFO_LEN_BITS;

    sample_pair_t mem [DEPTH];

    // Extra MSB tells full from empty
    logic [FIFO_LEN_BITS:0] wr_ptr_q;
    logic [FIFO_LEN_BITS:0] rd_ptr_q;
    logic [FIFO_LEN_BITS:0] level;
    logic                   do_wr;
    logic                   do_rd;

    assign level   = wr_ptr_q - rd_ptr_q;
    assign level_o = level;
    assign full_o  = level[FIFO_LEN_BITS];
    assign empty_o = (level == '0);

    // Drop writes when full, reads when empty
    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q[FIFO_LEN_BITS-1:0]] <= wr_data_i;
        end
    end

    // Head word shows without a read cycle
    assign rd_data_o = mem[rd_ptr_q[FIFO_LEN_BITS-1:0]];

endmodule

/* src/i2s_master.sv */
// I2S master transmitter
// Generates MCLK, SCLK and LRCLK and sends one 24-bit pair per 64-bit frame

`timescale 1ns/1ps

module i2s_master (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         enable_i,
    input  logic                         mclk_en_i,
    input  logic                         sclk_en_i,
    input  psoc_audio_pkg::sample_pair_t fifo_data_i,
    input  logic                         fifo_empty_i,
    output logic                         fifo_rd_o,
    output logic                         mclk_o,
    output logic                         sclk_o,
    output logic                         lrclk_o,
    output logic                         sdata_o
);

    import psoc_audio_pkg::*;

    logic                     mclk_q;
    logic                     sclk_q;
    logic                     lrclk_q;
    logic                     sdata_q;
    // Counts falling sclk edges within the frame
    logic [5:0]               bit_cnt_q;
    logic [5:0]               bit_cnt_next;
    logic [4:0]               slot;
    logic                     sclk_fall;
    logic                     frame_start;
    logic                     data_slot;
    logic [2*SAMPLE_BITS-1:0] shift_q;

    assign sclk_fall    = enable_i && sclk_en_i && sclk_q;
    assign bit_cnt_next = bit_cnt_q + 6'd1;
    assign slot         = bit_cnt_next[4:0];
    assign frame_start  = sclk_fall && (bit_cnt_next == '0);

    // Slot 0 of each half is the one-bit delay after LRCLK
    assign data_slot = (slot != '0) && (slot <= SAMPLE_BITS);

    // Pop together with the load at frame start
    assign fifo_rd_o = frame_start && !fifo_empty_i;

    always_ff @(posedge clk) begin
        if (rst_i || !enable_i) begin
            mclk_q    <= 1'b0;
            sclk_q    <= 1'b0;
            lrclk_q   <= 1'b0;
            sdata_q   <= 1'b0;
            bit_cnt_q <= '1;
        end else begin
            if (mclk_en_i) begin
                mclk_q <= ~mclk_q;
            end
            if (sclk_en_i) begin
                sclk_q <= ~sclk_q;
            end
            // LRCLK and data change on the falling sclk edge
            if (sclk_fall) begin
                bit_cnt_q <= bit_cnt_next;
                lrclk_q   <= bit_cnt_next[5];
                if (data_slot) begin
                    sdata_q <= shift_q[2*SAMPLE_BITS-1];
                end else begin
                    sdata_q <= 1'b0;
                end
            end
        end
    end

    // Left bits shift out first, then right
    always_ff @(posedge clk) begin
        if (frame_start) begin
            shift_q <= fifo_empty_i ? '0 : fifo_data_i;
        end else if (sclk_fall && data_slot) begin
            shift_q <= {shift_q[2*SAMPLE_BITS-2:0], 1'b0};
        end
    end

    assign mclk_o  = mclk_q;
    assign sclk_o  = sclk_q;
    assign lrclk_o = lrclk_q;
    assign sdata_o = sdata_q;

endmodule

/* src/sigma_delta_dac.sv */
// Stereo sigma-delta DAC
// First-order modulators with one-bit outputs, fed from the sample FIFO

`timescale 1ns/1ps

module sigma_delta_dac #(
    parameter int DAC_SAMPLE_DIV = 256
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         enable_i,
    input  psoc_audio_pkg::sample_pair_t fifo_data_i,
    input  logic                         fifo_empty_i,
    output logic                         fifo_rd_o,
    output logic                         phone_l_o,
    output logic                         phone_r_o
);

    import psoc_audio_pkg::*;

    localparam int DIV_BITS = $clog2(DAC_SAMPLE_DIV);

    logic [DIV_BITS-1:0]  div_q;
    sample_pair_t         sample_q;
    logic [SAMPLE_BITS:0] acc_l_q;
    logic [SAMPLE_BITS:0] acc_r_q;

    // Add offset-binary sample to the accumulator, carry lands in the MSB
    function automatic logic [SAMPLE_BITS:0] sd_step(
        input logic [SAMPLE_BITS:0]   acc,
        input logic [SAMPLE_BITS-1:0] sample
    );
        logic [SAMPLE_BITS-1:0] offset;
        offset = {~sample[SAMPLE_BITS-1], sample[SAMPLE_BITS-2:0]};
        return {1'b0, acc[SAMPLE_BITS-1:0]} + {1'b0, offset};
    endfunction

    // One pop per sample period, skipped when empty
    assign fifo_rd_o = enable_i && (div_q == '1) && !fifo_empty_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_q    <= '0;
            sample_q <= '0;
            acc_l_q  <= '0;
            acc_r_q  <= '0;
        end else if (!enable_i) begin
            div_q   <= '0;
            acc_l_q <= '0;
            acc_r_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
            // Last sample is held while the FIFO is empty
            if (fifo_rd_o) begin
                sample_q <= fifo_data_i;
            end
            acc_l_q <= sd_step(acc_l_q, sample_q.left);
            acc_r_q <= sd_step(acc_r_q, sample_q.right);
        end
    end

    assign phone_l_o = acc_l_q[SAMPLE_BITS];
    assign phone_r_o = acc_r_q[SAMPLE_BITS];

endmodule

/* src/audio_wb_regfile.sv */
// Audio Wishbone register file
// Single-ack slave holding CTRL, threshold and the pending left sample

`timescale 1ns/1ps

module audio_wb_regfile #(
    parameter int FIFO_LEN_BITS = 8
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic [31:0]                  wb_adr_i,
    input  logic [31:0]                  wb_dat_i,
    input  logic                         wb_we_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_cyc_i,
    output logic [31:0]                  wb_dat_o,
    output logic                         wb_ack_o,
    input  logic                         fifo_full_i,
    input  logic                         fifo_empty_i,
    input  logic                         fifo_low_i,
    input  logic [FIFO_LEN_BITS:0]       fifo_level_i,
    output psoc_audio_pkg::sample_pair_t sample_o,
    output logic                         sample_wr_o,
    audio_ctrl_if.ctrl                   ctrl_o
);

    import psoc_audio_pkg::*;

    logic [4:0]             reg_adr;
    logic                   access;
    logic                   wr_en;
    logic [31:0]            ctrl_word;
    logic [31:0]            status_word;
    logic [31:0]            rd_word;
    logic                   ack_q;
    logic [31:0]            dat_q;
    logic                   i2s_en_q;
    logic                   dac_en_q;
    logic                   dac_mode_q;
    logic                   sw_rst_q;
    logic [FIFO_LEN_BITS:0] thresh_q;
    logic                   sample_wr_q;
    logic [SAMPLE_BITS-1:0] left_q;
    logic [SAMPLE_BITS-1:0] right_q;

    assign reg_adr = wb_adr_i[4:0];

    // New access only while ack is low, so ack lasts one cycle
    assign access = wb_stb_i && wb_cyc_i && !ack_q;
    assign wr_en  = access && wb_we_i;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_I2S_EN]   = i2s_en_q;
        ctrl_word[CTRL_DAC_EN]   = dac_en_q;
        ctrl_word[CTRL_DAC_MODE] = dac_mode_q;

        status_word = '0;
        status_word[0] = fifo_full_i;
        status_word[1] = fifo_empty_i;
        status_word[2] = fifo_low_i;
        status_word[8 +: FIFO_LEN_BITS+1] = fifo_level_i;

        // Sample registers are write-only
        case (reg_adr)
            REG_CTRL:   rd_word = ctrl_word;
            REG_STATUS: rd_word = status_word;
            REG_THRESH: rd_word = 32'(thresh_q);
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q       <= 1'b0;
            i2s_en_q    <= 1'b0;
            dac_en_q    <= 1'b0;
            dac_mode_q  <= 1'b0;
            sw_rst_q    <= 1'b0;
            thresh_q    <= (FIFO_LEN_BITS+1)'(THRESH_RESET);
            sample_wr_q <= 1'b0;
        end else begin
            ack_q       <= access;
            sw_rst_q    <= 1'b0;
            sample_wr_q <= 1'b0;
            if (wr_en) begin
                case (reg_adr)
                    REG_CTRL: begin
                        i2s_en_q   <= wb_dat_i[CTRL_I2S_EN];
                        dac_en_q   <= wb_dat_i[CTRL_DAC_EN];
                        dac_mode_q <= wb_dat_i[CTRL_DAC_MODE];
                        sw_rst_q   <= wb_dat_i[CTRL_SW_RST];
                    end
                    REG_THRESH: thresh_q <= wb_dat_i[FIFO_LEN_BITS:0];
                    // Right write completes the pair
                    REG_RIGHT:  sample_wr_q <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Read data and sample payload
    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= rd_word;
        end
        if (wr_en && reg_adr == REG_LEFT) begin
            left_q <= wb_dat_i[SAMPLE_BITS-1:0];
        end
        if (wr_en && reg_adr == REG_RIGHT) begin
            right_q <= wb_dat_i[SAMPLE_BITS-1:0];
        end
    end

    assign wb_ack_o    = ack_q;
    assign wb_dat_o    = dat_q;
    assign sample_wr_o = sample_wr_q;
    assign sample_o    = '{left: left_q, right: right_q};

    assign ctrl_o.i2s_enable = i2s_en_q;
    assign ctrl_o.dac_enable = dac_en_q;
    assign ctrl_o.dac_mode   = dac_mode_q;
    assign ctrl_o.sw_rst     = sw_rst_q;
    assign ctrl_o.threshold  = thresh_q;

endmodule

/* src/psoc_audio.sv */
// Audio output peripheral top level
// Wishbone registers, sample FIFO, I2S master and sigma-delta DAC

`timescale 1ns/1ps

module psoc_audio #(
    parameter int FIFO_LEN_BITS  = 8,
    parameter int DAC_SAMPLE_DIV = 256
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_stb_i,
    input  logic        wb_cyc_i,
    output logic        wb_ack_o,
    output logic        fifo_low_o,
    output logic        i2s_mclk_o,
    output logic        i2s_sclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_sdata_o,
    output logic        phone_l_o,
    output logic        phone_r_o
);

    import psoc_audio_pkg::*;

    audio_ctrl_if #(.FIFO_LEN_BITS(FIFO_LEN_BITS)) ctrl_bus ();

    logic                   dev_rst;
    logic                   clk_en_4;
    logic                   clk_en_16;
    sample_pair_t           fifo_wr_data;
    sample_pair_t           fifo_rd_data;
    logic                   fifo_wr;
    logic                   fifo_rd;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   fifo_low;
    logic [FIFO_LEN_BITS:0] fifo_level;
    logic                   i2s_rd;
    logic                   dac_rd;

    // Soft reset clears the datapath but not the registers
    assign dev_rst = rst_i | ctrl_bus.sw_rst;

    // Only one consumer owns the FIFO read side
    assign fifo_rd = ctrl_bus.dac_mode ? dac_rd : i2s_rd;

    // Level output usable as an interrupt line
    assign fifo_low   = fifo_level < ctrl_bus.threshold;
    assign fifo_low_o = fifo_low;

    clock_generator u_clk_gen (
        .clk         (clk),
        .rst_i       (dev_rst),
        .clk_en_4_o  (clk_en_4),
        .clk_en_16_o (clk_en_16)
    );

    sample_fifo #(.FIFO_LEN_BITS(FIFO_LEN_BITS)) u_fifo (
        .clk       (clk),
        .rst_i     (dev_rst),
        .wr_i      (fifo_wr),
        .wr_data_i (fifo_wr_data),
        .rd_i      (fifo_rd),
        .rd_data_o (fifo_rd_data),
        .empty_o   (fifo_empty),
        .full_o    (fifo_full),
        .level_o   (fifo_level)
    );

    i2s_master u_i2s (
        .clk          (clk),
        .rst_i        (dev_rst),
        .enable_i     (ctrl_bus.i2s_enable),
        .mclk_en_i    (clk_en_4),
        .sclk_en_i    (clk_en_16),
        .fifo_data_i  (fifo_rd_data),
        .fifo_empty_i (fifo_empty),
        .fifo_rd_o    (i2s_rd),
        .mclk_o       (i2s_mclk_o),
        .sclk_o       (i2s_sclk_o),
        .lrclk_o      (i2s_lrclk_o),
        .sdata_o      (i2s_sdata_o)
    );

    sigma_delta_dac #(.DAC_SAMPLE_DIV(DAC_SAMPLE_DIV)) u_dac (
        .clk          (clk),
        .rst_i        (dev_rst),
        .enable_i     (ctrl_bus.dac_enable),
        .fifo_data_i  (fifo_rd_data),
        .fifo_empty_i (fifo_empty),
        .fifo_rd_o    (dac_rd),
        .phone_l_o    (phone_l_o),
        .phone_r_o    (phone_r_o)
    );

    // Byte lanes on wb_sel_i are not decoded
    audio_wb_regfile #(.FIFO_LEN_BITS(FIFO_LEN_BITS)) u_regs (
        .clk          (clk),
        .rst_i        (rst_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_we_i      (wb_we_i),
        .wb_stb_i     (wb_stb_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .fifo_low_i   (fifo_low),
        .fifo_level_i (fifo_level),
        .sample_o     (fifo_wr_data),
        .sample_wr_o  (fifo_wr),
        .ctrl_o       (ctrl_bus.ctrl)
    );

endmodule

/* bench/psoc_audio_tb.sv */
// Audio peripheral testbench
// Drives Wishbone accesses and checks registers, FIFO, I2S, DAC and soft reset

`timescale 1ns/1ps

module psoc_audio_tb;

    import psoc_audio_pkg::*;

    localparam int FIFO_LEN_BITS  = 8;
    localparam int DAC_SAMPLE_DIV = 256;
    localparam int DEPTH          = 1 << FIFO_LEN_BITS;
    localparam int NUM_PAIRS      = 20;
    localparam int ZERO_FRAMES    = 2;
    localparam int DAC_PAIRS      = 3;
    localparam int ACK_WAIT       = 16;
    // 64 sclk periods of 32 clk each
    localparam int FRAME_CLKS     = 64 * 32;
    // MCLK period in clk cycles
    localparam int MCLK_CLKS      = 8;
    // Twice the I2S test plus room for the short tests
    localparam int CYCLE_LIMIT    = 2 * (NUM_PAIRS + ZERO_FRAMES + 1) * FRAME_CLKS + 8000;

    logic        clk;
    logic        rst_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_we_i;
    logic [3:0]  wb_sel_i;
    logic        wb_stb_i;
    logic        wb_cyc_i;
    logic        wb_ack_o;
    logic        fifo_low_o;
    logic        i2s_mclk_o;
    logic        i2s_sclk_o;
    logic        i2s_lrclk_o;
    logic        i2s_sdata_o;
    logic        phone_l_o;
    logic        phone_r_o;

    string        test_name;
    int           test_errs;
    int           err_total;
    int           tests_run;
    int           tests_failed;
    int           cycle_cnt   = 0;
    logic [31:0]  lfsr_state  = 32'h3a939539;
    sample_pair_t ref_q[$];

    // I2S capture state
    logic                   capture_on;
    logic                   sclk_prev   = 1'b0;
    logic                   lrclk_prev  = 1'b0;
    logic                   mclk_prev   = 1'b0;
    logic                   have_left   = 1'b0;
    logic                   frame_timed = 1'b0;
    logic [31:0]            half_bits   = '0;
    logic [SAMPLE_BITS-1:0] cap_left    = '0;
    int                     frames_seen = 0;
    int                     mclk_rises  = 0;

    psoc_audio #(
        .FIFO_LEN_BITS  (FIFO_LEN_BITS),
        .DAC_SAMPLE_DIV (DAC_SAMPLE_DIV)
    ) dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_stb_i    (wb_stb_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_ack_o    (wb_ack_o),
        .fifo_low_o  (fifo_low_o),
        .i2s_mclk_o  (i2s_mclk_o),
        .i2s_sclk_o  (i2s_sclk_o),
        .i2s_lrclk_o (i2s_lrclk_o),
        .i2s_sdata_o (i2s_sdata_o),
        .phone_l_o   (phone_l_o),
        .phone_r_o   (phone_r_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles during %s", CYCLE_LIMIT, test_name);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Expected STATUS word for a fill level and threshold
    function automatic logic [31:0] status_ref(input int level, input int thresh);
        logic [31:0] w;
        w = '0;
        w[0] = (level == DEPTH);
        w[1] = (level == 0);
        w[2] = (level < thresh);
        w[8 +: FIFO_LEN_BITS+1] = (FIFO_LEN_BITS+1)'(level);
        return w;
    endfunction

    // Ones in one sample period for a constant sample
    function automatic int dac_ones_ref(input logic [SAMPLE_BITS-1:0] s);
        logic [SAMPLE_BITS-1:0] offset;
        offset = {~s[SAMPLE_BITS-1], s[SAMPLE_BITS-2:0]};
        return int'((longint'(offset) * DAC_SAMPLE_DIV) >>> SAMPLE_BITS);
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        test_errs++;
        err_total++;
    endtask

    task automatic check_value(input string what, input logic [47:0] exp,
                               input logic [47:0] act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    task automatic check_near(input string what, input int exp, input int act);
        if (act > exp + 1 || act < exp - 1) begin
            $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    // Single Wishbone cycle with a one-clock ack
    task automatic bus_access(input logic we, input logic [4:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_adr_i = 32'(adr);
        wb_dat_i = wdata;
        wb_we_i  = we;
        wb_stb_i = 1'b1;
        wb_cyc_i = 1'b1;
        @(negedge clk);
        while (!wb_ack_o && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        rdata = wb_dat_o;
        if (!wb_ack_o) begin
            report_failure("the Wishbone ack never came");
        end
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        if (wb_ack_o) begin
            report_failure("the Wishbone ack stayed high for more than one cycle");
        end
    endtask

    task automatic reg_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] unused_rd;
        bus_access(1'b1, adr, data, unused_rd);
    endtask

    task automatic reg_read(input logic [4:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic write_pair(input logic [SAMPLE_BITS-1:0] l, input logic [SAMPLE_BITS-1:0] r);
        reg_write(REG_LEFT, {8'd0, l});
        reg_write(REG_RIGHT, {8'd0, r});
    endtask

    task automatic compare_frame(input sample_pair_t got);
        sample_pair_t exp;
        if (ref_q.size() > 0) begin
            exp = ref_q.pop_front();
        end else begin
            exp = '0;
        end
        check_value("I2S frame", 48'(exp), 48'(got));
    endtask

    // Delay slot and the slots after the 24 data bits carry zeros
    task automatic check_padding();
        check_value("I2S padding bits", '0, 48'({half_bits[31], half_bits[6:0]}));
    endtask

    // Bits shift in on rising sclk and a half closes at each lrclk edge
    always @(negedge clk) begin
        sclk_prev  <= i2s_sclk_o;
        lrclk_prev <= i2s_lrclk_o;
        mclk_prev  <= i2s_mclk_o;
        if (!capture_on) begin
            have_left   <= 1'b0;
            frame_timed <= 1'b0;
        end else begin
            if (i2s_sclk_o && !sclk_prev) begin
                half_bits <= {half_bits[30:0], i2s_sdata_o};
            end
            if (i2s_mclk_o && !mclk_prev) begin
                mclk_rises <= mclk_rises + 1;
            end
            // Slot 0 holds the delay bit and slots 1 to 24 the data
            if (i2s_lrclk_o && !lrclk_prev) begin
                cap_left  <= half_bits[30:7];
                have_left <= 1'b1;
                check_padding();
            end
            if (!i2s_lrclk_o && lrclk_prev && have_left) begin
                compare_frame('{left: cap_left, right: half_bits[30:7]});
                check_padding();
                frames_seen <= frames_seen + 1;
            end
            // MCLK rises between two frame starts, the one on the later edge included
            if (!i2s_lrclk_o && lrclk_prev) begin
                if (frame_timed) begin
                    check_value("MCLK rises per frame", 48'(FRAME_CLKS / MCLK_CLKS),
                                48'(mclk_rises + ((i2s_mclk_o && !mclk_prev) ? 1 : 0)));
                end
                mclk_rises  <= 0;
                frame_timed <= 1'b1;
            end
        end
    end

    initial begin
        logic [31:0]            rd;
        logic [31:0]            val;
        logic [SAMPLE_BITS-1:0] smp_l;
        logic [SAMPLE_BITS-1:0] smp_r;
        int                     ones_l;
        int                     ones_r;
        int                     level;
        int                     i;

        rst_i        = 1'b1;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_we_i      = 1'b0;
        wb_sel_i     = 4'hf;
        wb_stb_i     = 1'b0;
        wb_cyc_i     = 1'b0;
        capture_on   = 1'b0;
        test_name    = "reset";
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst_i = 1'b0;

        start_test("reset_state");
        @(negedge clk);
        check_value("fifo_low_o", 48'd1, 48'(fifo_low_o));
        check_value("I2S lines", '0, 48'({i2s_mclk_o, i2s_sclk_o, i2s_lrclk_o, i2s_sdata_o}));
        check_value("phone lines", '0, 48'({phone_l_o, phone_r_o}));
        check_value("wb_ack_o", '0, 48'(wb_ack_o));
        reg_read(REG_CTRL, rd);
        check_value("CTRL", '0, 48'(rd));
        reg_read(REG_THRESH, rd);
        check_value("THRESH", 48'(THRESH_RESET), 48'(rd));
        reg_read(REG_STATUS, rd);
        check_value("STATUS", 48'(status_ref(0, THRESH_RESET)), 48'(rd));
        end_test();

        start_test("register_access");
        for (i = 0; i < 8; i++) begin
            rand_bits(FIFO_LEN_BITS + 1, val);
            reg_write(REG_THRESH, val);
            reg_read(REG_THRESH, rd);
            check_value("THRESH readback", 48'(val), 48'(rd));
        end
        reg_write(REG_THRESH, 32'(THRESH_RESET));
        end_test();

        start_test("fifo_level");
        for (i = 0; i < NUM_PAIRS; i++) begin
            rand_bits(SAMPLE_BITS, val);
            smp_l = val[SAMPLE_BITS-1:0];
            rand_bits(SAMPLE_BITS, val);
            smp_r = val[SAMPLE_BITS-1:0];
            write_pair(smp_l, smp_r);
            ref_q.push_back('{left: smp_l, right: smp_r});
        end
        reg_read(REG_STATUS, rd);
        check_value("STATUS", 48'(status_ref(NUM_PAIRS, THRESH_RESET)), 48'(rd));
        reg_write(REG_THRESH, 32'd10);
        check_value("fifo_low_o", '0, 48'(fifo_low_o));
        reg_read(REG_STATUS, rd);
        check_value("STATUS", 48'(status_ref(NUM_PAIRS, 10)), 48'(rd));
        reg_write(REG_THRESH, 32'd30);
        check_value("fifo_low_o", 48'd1, 48'(fifo_low_o));
        reg_read(REG_STATUS, rd);
        check_value("STATUS", 48'(status_ref(NUM_PAIRS, 30)), 48'(rd));
        end_test();

        start_test("i2s_data");
        capture_on = 1'b1;
        reg_write(REG_CTRL, 32'(1 << CTRL_I2S_EN));
        while (frames_seen < NUM_PAIRS + ZERO_FRAMES) begin
            @(negedge clk);
        end
        capture_on = 1'b0;
        check_value("pairs never sent", '0, 48'(ref_q.size()));
        reg_read(REG_STATUS, rd);
        check_value("STATUS", 48'(status_ref(0, 30)), 48'(rd));
        reg_write(REG_CTRL, '0);
        end_test();

        start_test("dac_mode");
        rand_bits(SAMPLE_BITS, val);
        smp_l = val[SAMPLE_BITS-1:0];
        rand_bits(SAMPLE_BITS, val);
        smp_r = val[SAMPLE_BITS-1:0];
        reg_write(REG_CTRL, 32'((1 << CTRL_DAC_EN) | (1 << CTRL_DAC_MODE)));
        for (i = 0; i < DAC_PAIRS; i++) begin
            write_pair(smp_l, smp_r);
        end
        // Wait for the first pop so the modulators run on the constant pair
        level = DAC_PAIRS;
        while (level >= DAC_PAIRS) begin
            reg_read(REG_STATUS, rd);
            level = int'(rd[8 +: FIFO_LEN_BITS+1]);
        end
        ones_l = 0;
        ones_r = 0;
        for (i = 0; i < DAC_SAMPLE_DIV; i++) begin
            @(negedge clk);
            if (phone_l_o) begin
                ones_l++;
            end
            if (phone_r_o) begin
                ones_r++;
            end
        end
        check_near("phone_l_o ones", dac_ones_ref(smp_l), ones_l);
        check_near("phone_r_o ones", dac_ones_ref(smp_r), ones_r);
        while (level != 0) begin
            reg_read(REG_STATUS, rd);
            level = int'(rd[8 +: FIFO_LEN_BITS+1]);
        end
        check_value("STATUS", 48'(status_ref(0, 30)), 48'(rd));
        reg_write(REG_CTRL, '0);
        end_test();

        start_test("software_reset");
        reg_write(REG_THRESH, 32'd40);
        reg_write(REG_CTRL, 32'(1 << CTRL_DAC_EN));
        for (i = 0; i < DEPTH; i++) begin
            write_pair(SAMPLE_BITS'(i), SAMPLE_BITS'(DEPTH - i));
        end
        // This one is dropped by the full FIFO
        write_pair(24'h123456, 24'h654321);
        reg_read(REG_STATUS, rd);
        check_value("STATUS when full", 48'(status_ref(DEPTH, 40)), 48'(rd));
        reg_write(REG_CTRL, 32'((1 << CTRL_DAC_EN) | (1 << CTRL_SW_RST)));
        reg_read(REG_STATUS, rd);
        check_value("STATUS after reset", 48'(status_ref(0, 40)), 48'(rd));
        reg_read(REG_THRESH, rd);
        check_value("THRESH", 48'd40, 48'(rd));
        reg_read(REG_CTRL, rd);
        check_value("CTRL", 48'(1 << CTRL_DAC_EN), 48'(rd));
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
src/psoc_audio_pkg.sv
src/audio_ctrl_if.sv
src/clock_generator.sv
src/sample_fifo.sv
src/i2s_master.sv
src/sigma_delta_dac.sv
src/audio_wb_regfile.sv
src/psoc_audio.sv
bench/psoc_audio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing -j 0 -f sim.f --top-module psoc_audio_tb \
    -Mdir obj_dir -o psoc_audio_sim \
    && ./obj_dir/psoc_audio_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
